//--- hw/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

`define CSR_DATA_W      32
`define CSR_NUM_W       14
`define ECODE_W         6
`define ESUBCODE_W      9
`define INT_W           13

// CSR numbers
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ECFG        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_BADV        14'h007
`define CSR_EENTRY      14'h00c
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033
`define CSR_TID         14'h040
`define CSR_TCFG        14'h041
`define CSR_TVAL        14'h042
`define CSR_TICLR       14'h044

// Field positions
`define CRMD_PLV        1:0
`define CRMD_IE         2
`define CRMD_DA         3
`define CRMD_PG         4
`define PRMD_PPLV       1:0
`define PRMD_PIE        2
`define ESTAT_IS_SW     1:0
`define TCFG_EN         0
`define TCFG_PERIODIC   1
`define TCFG_INITVAL    31:2
`define TICLR_CLR       0

// LIE bit 10 is reserved
`define ECFG_LIE_MASK   13'h1bff

// Counter value of a stopped timer
`define TIMER_IDLE      32'hffff_ffff

`endif

//--- hw/csr_pkg.sv
`default_nettype none

`include "csr_params.svh"

package csr_pkg;

    typedef logic [`CSR_NUM_W-1:0]  csr_num_t;
    typedef logic [`CSR_DATA_W-1:0] csr_data_t;

    // Bits under the mask take the new value, the rest keep the old one
    function automatic csr_data_t masked_write(
        input csr_data_t old_value,
        input csr_data_t wvalue,
        input csr_data_t wmask
    );
        return (wvalue & wmask) | (old_value & ~wmask);
    endfunction

endpackage

`default_nettype wire

//--- hw/exc_pkg.sv
`default_nettype none

`include "csr_params.svh"

package exc_pkg;

    typedef logic [1:0] plv_t;

    typedef enum logic [`ECODE_W-1:0] {
        ECODE_INT = `ECODE_W'h00,
        ECODE_ADE = `ECODE_W'h08,
        ECODE_ALE = `ECODE_W'h09,
        ECODE_SYS = `ECODE_W'h0b,
        ECODE_BRK = `ECODE_W'h0c,
        ECODE_INE = `ECODE_W'h0d
    } ecode_t;

    typedef logic [`ESUBCODE_W-1:0] esubcode_t;

    // Fetch address error
    localparam esubcode_t ESUBCODE_ADEF = `ESUBCODE_W'h000;

endpackage

`default_nettype wire

//--- hw/csr_exc_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "csr_params.svh"

module csr_exc_regs (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 csr_wr,
    input  csr_pkg::csr_num_t         csr_num,
    input  csr_pkg::csr_data_t        csr_wvalue,
    input  csr_pkg::csr_data_t        csr_wmask,
    input  wire logic                 wb_ex,
    input  wire logic                 ertn_flush,
    input  exc_pkg::ecode_t           wb_ecode,
    input  exc_pkg::esubcode_t        wb_esubcode,
    input  csr_pkg::csr_data_t        wb_pc,
    input  csr_pkg::csr_data_t        wb_vaddr,
    input  wire logic                 timer_int,
    output csr_pkg::csr_data_t        rdata,
    output csr_pkg::csr_data_t        ex_entry,
    output csr_pkg::csr_data_t        era_pc,
    output csr_pkg::csr_data_t        csr_crmd,
    output logic                      has_int
);

    exc_pkg::plv_t          crmd_plv;
    logic                   crmd_ie;
    logic                   crmd_da;
    logic                   crmd_pg;
    exc_pkg::plv_t          prmd_pplv;
    logic                   prmd_pie;
    logic [`INT_W-1:0]      ecfg_lie;
    logic [1:0]             estat_is_sw;
    logic [`INT_W-1:0]      estat_is;
    exc_pkg::ecode_t        estat_ecode;
    exc_pkg::esubcode_t     estat_esubcode;
    csr_pkg::csr_data_t     era;
    logic [25:0]            eentry_va;
    csr_pkg::csr_data_t     badv;

    csr_pkg::csr_data_t     crmd_rvalue;
    csr_pkg::csr_data_t     prmd_rvalue;
    csr_pkg::csr_data_t     ecfg_rvalue;
    csr_pkg::csr_data_t     estat_rvalue;
    csr_pkg::csr_data_t     eentry_rvalue;
    logic                   addr_err;

    assign crmd_rvalue   = csr_pkg::csr_data_t'({crmd_pg, crmd_da, crmd_ie, crmd_plv});
    assign prmd_rvalue   = csr_pkg::csr_data_t'({prmd_pie, prmd_pplv});
    assign ecfg_rvalue   = csr_pkg::csr_data_t'(ecfg_lie);
    assign estat_rvalue  = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
    assign eentry_rvalue = {eentry_va, 6'b0};

    // IS[12] and IS[9:2] have no source in this core
    assign estat_is = {1'b0, timer_int, 9'b0, estat_is_sw};

    // CRMD: exception entry beats return, return beats software
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
            crmd_da  <= 1'b1;
            crmd_pg  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_wr && csr_num == `CSR_CRMD) begin
            crmd_plv <= csr_pkg::masked_write(crmd_rvalue, csr_wvalue, csr_wmask)[`CRMD_PLV];
            crmd_ie  <= csr_pkg::masked_write(crmd_rvalue, csr_wvalue, csr_wmask)[`CRMD_IE];
            crmd_da  <= csr_pkg::masked_write(crmd_rvalue, csr_wvalue, csr_wmask)[`CRMD_DA];
            crmd_pg  <= csr_pkg::masked_write(crmd_rvalue, csr_wvalue, csr_wmask)[`CRMD_PG];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_wr && csr_num == `CSR_PRMD) begin
            prmd_pplv <= csr_pkg::masked_write(prmd_rvalue, csr_wvalue, csr_wmask)[`PRMD_PPLV];
            prmd_pie  <= csr_pkg::masked_write(prmd_rvalue, csr_wvalue, csr_wmask)[`PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie    <= '0;
            estat_is_sw <= '0;
        end else begin
            if (csr_wr && csr_num == `CSR_ECFG) begin
                ecfg_lie <= csr_pkg::masked_write(ecfg_rvalue, csr_wvalue, csr_wmask)[`INT_W-1:0]
                            & `ECFG_LIE_MASK;
            end
            if (csr_wr && csr_num == `CSR_ESTAT) begin
                estat_is_sw <= csr_pkg::masked_write(estat_rvalue, csr_wvalue,
                                                     csr_wmask)[`ESTAT_IS_SW];
            end
        end
    end

    assign addr_err = (wb_ecode == exc_pkg::ECODE_ADE) || (wb_ecode == exc_pkg::ECODE_ALE);

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
            era            <= wb_pc;
        end else if (csr_wr && csr_num == `CSR_ERA) begin
            era <= csr_pkg::masked_write(era, csr_wvalue, csr_wmask);
        end
        // Fetch errors record the PC, data errors the access address
        if (wb_ex && addr_err) begin
            badv <= (wb_ecode == exc_pkg::ECODE_ADE && wb_esubcode == exc_pkg::ESUBCODE_ADEF)
                    ? wb_pc : wb_vaddr;
        end
        if (csr_wr && csr_num == `CSR_EENTRY) begin
            eentry_va <= csr_pkg::masked_write(eentry_rvalue, csr_wvalue, csr_wmask)[31:6];
        end
    end

    always_comb begin
        case (csr_num)
            `CSR_CRMD:   rdata = crmd_rvalue;
            `CSR_PRMD:   rdata = prmd_rvalue;
            `CSR_ECFG:   rdata = ecfg_rvalue;
            `CSR_ESTAT:  rdata = estat_rvalue;
            `CSR_ERA:    rdata = era;
            `CSR_BADV:   rdata = badv;
            `CSR_EENTRY: rdata = eentry_rvalue;
            default:     rdata = '0;
        endcase
    end

    assign has_int  = (|(estat_is & ecfg_lie)) && crmd_ie;
    assign ex_entry = eentry_rvalue;
    assign era_pc   = era;
    assign csr_crmd = crmd_rvalue;

    // Pipeline retires at most one of these per cycle
    a_ex_ertn_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(wb_ex && ertn_flush)
    );

endmodule

`default_nettype wire

//--- hw/csr_timer.sv
`default_nettype none
`timescale 1ns/1ps

`include "csr_params.svh"

module csr_timer (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             csr_wr,
    input  csr_pkg::csr_num_t     csr_num,
    input  csr_pkg::csr_data_t    csr_wvalue,
    input  csr_pkg::csr_data_t    csr_wmask,
    output csr_pkg::csr_data_t    rdata,
    output logic                  timer_int
);

    csr_pkg::csr_data_t     tid;
    logic                   tcfg_en;
    logic                   tcfg_periodic;
    logic [29:0]            tcfg_initval;
    csr_pkg::csr_data_t     timer_cnt;
    csr_pkg::csr_data_t     tcfg_rvalue;
    csr_pkg::csr_data_t     tcfg_next;
    logic                   tcfg_wr;
    logic                   ticlr_wr;

    assign tcfg_wr     = csr_wr && csr_num == `CSR_TCFG;
    assign ticlr_wr    = csr_wr && csr_num == `CSR_TICLR;
    assign tcfg_rvalue = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_next   = csr_pkg::masked_write(tcfg_rvalue, csr_wvalue, csr_wmask);

    always_ff @(posedge clk) begin
        if (reset) begin
            tid     <= '0;
            tcfg_en <= 1'b0;
        end else begin
            if (csr_wr && csr_num == `CSR_TID) begin
                tid <= csr_pkg::masked_write(tid, csr_wvalue, csr_wmask);
            end
            if (tcfg_wr) begin
                tcfg_en <= tcfg_next[`TCFG_EN];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_wr) begin
            tcfg_periodic <= tcfg_next[`TCFG_PERIODIC];
            tcfg_initval  <= tcfg_next[`TCFG_INITVAL];
        end
    end

    // Countdown; one-shot mode wraps from zero to idle and stops there
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= `TIMER_IDLE;
        end else if (tcfg_wr && tcfg_next[`TCFG_EN]) begin
            timer_cnt <= {tcfg_next[`TCFG_INITVAL], 2'b0};
        end else if (tcfg_en && timer_cnt != `TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b0};
            end else begin
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    // Set wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (timer_cnt == '0) begin
            timer_int <= 1'b1;
        end else if (ticlr_wr && csr_wmask[`TICLR_CLR] && csr_wvalue[`TICLR_CLR]) begin
            timer_int <= 1'b0;
        end
    end

    always_comb begin
        case (csr_num)
            `CSR_TID:   rdata = tid;
            `CSR_TCFG:  rdata = tcfg_rvalue;
            `CSR_TVAL:  rdata = timer_cnt;
            default:    rdata = '0;
        endcase
    end

    a_cnt_frozen_when_off: assert property (
        @(posedge clk) disable iff (reset)
        (!tcfg_wr && !tcfg_en) |=> $stable(timer_cnt)
    );

endmodule

`default_nettype wire

//--- hw/csr_save_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "csr_params.svh"

module csr_save_regs (
    input  wire logic             clk,
    input  wire logic             csr_wr,
    input  csr_pkg::csr_num_t     csr_num,
    input  csr_pkg::csr_data_t    csr_wvalue,
    input  csr_pkg::csr_data_t    csr_wmask,
    output csr_pkg::csr_data_t    rdata
);

    csr_pkg::csr_data_t     save [4];
    logic [3:0]             hit;

    assign hit[0] = csr_num == `CSR_SAVE0;
    assign hit[1] = csr_num == `CSR_SAVE1;
    assign hit[2] = csr_num == `CSR_SAVE2;
    assign hit[3] = csr_num == `CSR_SAVE3;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (csr_wr && hit[i]) begin
                save[i] <= csr_pkg::masked_write(save[i], csr_wvalue, csr_wmask);
            end
        end
    end

    // At most one hit bit is set
    always_comb begin
        rdata = '0;
        for (int i = 0; i < 4; i++) begin
            rdata = rdata | ({`CSR_DATA_W{hit[i]}} & save[i]);
        end
    end

endmodule

`default_nettype wire

//--- hw/csr_file.sv
`default_nettype none
`timescale 1ns/1ps

module csr_file (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             valid,
    input  csr_pkg::csr_num_t     csr_num,
    input  wire logic             csr_we,
    input  csr_pkg::csr_data_t    csr_wvalue,
    input  csr_pkg::csr_data_t    csr_wmask,
    input  wire logic             wb_ex,
    input  wire logic             ertn_flush,
    input  exc_pkg::ecode_t       wb_ecode,
    input  exc_pkg::esubcode_t    wb_esubcode,
    input  csr_pkg::csr_data_t    wb_pc,
    input  csr_pkg::csr_data_t    wb_vaddr,
    output csr_pkg::csr_data_t    csr_rvalue,
    output csr_pkg::csr_data_t    ex_entry,
    output csr_pkg::csr_data_t    era_pc,
    output csr_pkg::csr_data_t    csr_crmd,
    output logic                  has_int
);

    logic                   csr_wr;
    logic                   timer_int;
    csr_pkg::csr_data_t     exc_rdata;
    csr_pkg::csr_data_t     timer_rdata;
    csr_pkg::csr_data_t     save_rdata;

    // Only a valid instruction may write
    assign csr_wr = csr_we && valid;

    csr_exc_regs u_exc_regs (
        .clk         (clk),
        .reset       (reset),
        .csr_wr      (csr_wr),
        .csr_num     (csr_num),
        .csr_wvalue  (csr_wvalue),
        .csr_wmask   (csr_wmask),
        .wb_ex       (wb_ex),
        .ertn_flush  (ertn_flush),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .timer_int   (timer_int),
        .rdata       (exc_rdata),
        .ex_entry    (ex_entry),
        .era_pc      (era_pc),
        .csr_crmd    (csr_crmd),
        .has_int     (has_int)
    );

    csr_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .csr_wr     (csr_wr),
        .csr_num    (csr_num),
        .csr_wvalue (csr_wvalue),
        .csr_wmask  (csr_wmask),
        .rdata      (timer_rdata),
        .timer_int  (timer_int)
    );

    csr_save_regs u_save_regs (
        .clk        (clk),
        .csr_wr     (csr_wr),
        .csr_num    (csr_num),
        .csr_wvalue (csr_wvalue),
        .csr_wmask  (csr_wmask),
        .rdata      (save_rdata)
    );

    // Peers return zero for numbers they do not own
    assign csr_rvalue = exc_rdata | timer_rdata | save_rdata;

endmodule

`default_nettype wire

//--- verification/csr_file_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "csr_params.svh"

module csr_file_tb;

    localparam int cycle_limit = 1000;

    logic                   clk;
    logic                   reset;
    logic                   valid;
    csr_pkg::csr_num_t      csr_num;
    logic                   csr_we;
    csr_pkg::csr_data_t     csr_wvalue;
    csr_pkg::csr_data_t     csr_wmask;
    logic                   wb_ex;
    logic                   ertn_flush;
    exc_pkg::ecode_t        wb_ecode;
    exc_pkg::esubcode_t     wb_esubcode;
    csr_pkg::csr_data_t     wb_pc;
    csr_pkg::csr_data_t     wb_vaddr;
    csr_pkg::csr_data_t     csr_rvalue;
    csr_pkg::csr_data_t     ex_entry;
    csr_pkg::csr_data_t     era_pc;
    csr_pkg::csr_data_t     csr_crmd;
    logic                   has_int;
    int                     cycle_count = 0;
    int unsigned            seed_discard;

    csr_file u_dut (
        .clk         (clk),
        .reset       (reset),
        .valid       (valid),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wvalue  (csr_wvalue),
        .csr_wmask   (csr_wmask),
        .wb_ex       (wb_ex),
        .ertn_flush  (ertn_flush),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .csr_rvalue  (csr_rvalue),
        .ex_entry    (ex_entry),
        .era_pc      (era_pc),
        .csr_crmd    (csr_crmd),
        .has_int     (has_int)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Tests take about 200 cycles
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: tests still running after %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string what, input csr_pkg::csr_data_t got,
                               input csr_pkg::csr_data_t expected);
        assert (got === expected) else begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    // Called right after a falling edge
    task automatic drive_idle();
        valid      = 1'b1;
        csr_we     = 1'b0;
        wb_ex      = 1'b0;
        ertn_flush = 1'b0;
    endtask

    task automatic write_csr(input csr_pkg::csr_num_t num, input csr_pkg::csr_data_t value,
                             input csr_pkg::csr_data_t mask, input logic wr_valid);
        @(negedge clk);
        drive_idle();
        valid      = wr_valid;
        csr_we     = 1'b1;
        csr_num    = num;
        csr_wvalue = value;
        csr_wmask  = mask;
        @(posedge clk);
    endtask

    task automatic read_csr(input csr_pkg::csr_num_t num, output csr_pkg::csr_data_t data);
        @(negedge clk);
        drive_idle();
        csr_num = num;
        #1;
        data = csr_rvalue;
    endtask

    task automatic masked_write_readback();
        csr_pkg::csr_num_t  nums [6];
        csr_pkg::csr_data_t expected [6];
        csr_pkg::csr_data_t value;
        csr_pkg::csr_data_t mask;
        csr_pkg::csr_data_t data;
        nums = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_ERA, `CSR_EENTRY};
        for (int i = 0; i < 6; i++) begin
            value = $urandom;
            write_csr(nums[i], value, 32'hffff_ffff, 1'b1);
            expected[i] = value;
            value = $urandom;
            mask  = $urandom;
            write_csr(nums[i], value, mask, 1'b1);
            expected[i] = (expected[i] & ~mask) | (value & mask);
            // EENTRY keeps only the 64-byte aligned part
            if (nums[i] == `CSR_EENTRY) begin
                expected[i] = expected[i] & 32'hffff_ffc0;
            end
        end
        for (int i = 0; i < 6; i++) begin
            read_csr(nums[i], data);
            check_value($sformatf("CSR %h", nums[i]), data, expected[i]);
        end
        check_value("ex_entry", ex_entry, expected[5]);
        write_csr(`CSR_SAVE0, ~expected[0], 32'hffff_ffff, 1'b0);
        read_csr(`CSR_SAVE0, data);
        check_value("SAVE0 after write with valid low", data, expected[0]);
    endtask

    task automatic exception_entry(input exc_pkg::ecode_t ecode,
                                   input exc_pkg::esubcode_t subcode, input logic badv_is_pc);
        csr_pkg::csr_data_t pc;
        csr_pkg::csr_data_t vaddr;
        csr_pkg::csr_data_t data;
        pc    = $urandom;
        vaddr = $urandom;
        write_csr(`CSR_CRMD, 32'h0000_0007, 32'h0000_0007, 1'b1);
        read_csr(`CSR_CRMD, data);
        check_value("CRMD with PLV 3 and IE", data, 32'h0000_000f);
        @(negedge clk);
        drive_idle();
        wb_ex       = 1'b1;
        wb_ecode    = ecode;
        wb_esubcode = subcode;
        wb_pc       = pc;
        wb_vaddr    = vaddr;
        @(posedge clk);
        read_csr(`CSR_CRMD, data);
        check_value("CRMD after exception", data, 32'h0000_0008);
        read_csr(`CSR_PRMD, data);
        check_value("PRMD after exception", data, 32'h0000_0007);
        read_csr(`CSR_ERA, data);
        check_value("ERA", data, pc);
        check_value("era_pc", era_pc, pc);
        read_csr(`CSR_BADV, data);
        check_value("BADV", data, badv_is_pc ? pc : vaddr);
        read_csr(`CSR_ESTAT, data);
        check_value("ESTAT codes", data & 32'h7fff_0000, {1'b0, subcode, ecode, 16'b0});
    endtask

    task automatic exception_return();
        csr_pkg::csr_data_t value;
        csr_pkg::csr_data_t data;
        // Nonzero, so the restore differs from the post-exception CRMD
        value = ($urandom % 7) + 1;
        write_csr(`CSR_PRMD, value, 32'h0000_0007, 1'b1);
        @(negedge clk);
        drive_idle();
        ertn_flush = 1'b1;
        @(posedge clk);
        read_csr(`CSR_CRMD, data);
        // DA stays set, PLV and IE come back from PRMD
        check_value("CRMD after return", data, 32'h0000_0008 | value);
        check_value("csr_crmd", csr_crmd, 32'h0000_0008 | value);
    endtask

    task automatic oneshot_timer();
        csr_pkg::csr_data_t data;
        write_csr(`CSR_TCFG, 32'h0000_000d, 32'hffff_ffff, 1'b1);
        for (int k = 0; k <= 12; k++) begin
            read_csr(`CSR_TVAL, data);
            check_value($sformatf("TVAL at step %0d", k), data, 32'(12 - k));
        end
        // Still clear in the cycle that TVAL reads zero
        csr_num = `CSR_ESTAT;
        #1;
        check_value("ESTAT.IS[11] while TVAL is zero", csr_rvalue[11], 0);
        read_csr(`CSR_ESTAT, data);
        check_value("ESTAT.IS[11] after expiry", data[11], 1);
        read_csr(`CSR_TVAL, data);
        check_value("TVAL after one-shot", data, `TIMER_IDLE);
        write_csr(`CSR_TICLR, 32'h0000_0001, 32'h0000_0001, 1'b1);
        for (int k = 0; k < 5; k++) begin
            read_csr(`CSR_ESTAT, data);
            check_value("ESTAT.IS[11] after clear", data[11], 0);
        end
    endtask

    // Each period is 9 cycles; slots 1 to 3 check and clear the interrupt
    task automatic periodic_timer();
        csr_pkg::csr_data_t data;
        write_csr(`CSR_TCFG, 32'h0000_000b, 32'hffff_ffff, 1'b1);
        for (int p = 0; p < 3; p++) begin
            for (int k = 0; k <= 8; k++) begin
                if (k == 1) begin
                    read_csr(`CSR_ESTAT, data);
                    check_value($sformatf("ESTAT.IS[11] in period %0d", p), data[11], p != 0);
                end else if (k == 2) begin
                    write_csr(`CSR_TICLR, 32'h0000_0001, 32'h0000_0001, 1'b1);
                end else if (k == 3) begin
                    read_csr(`CSR_ESTAT, data);
                    check_value("ESTAT.IS[11] after clear", data[11], 0);
                end else begin
                    read_csr(`CSR_TVAL, data);
                    check_value($sformatf("TVAL in period %0d", p), data, 32'(8 - k));
                end
            end
        end
        write_csr(`CSR_TCFG, 32'h0000_0000, 32'hffff_ffff, 1'b1);
        write_csr(`CSR_TICLR, 32'h0000_0001, 32'h0000_0001, 1'b1);
        read_csr(`CSR_ESTAT, data);
        check_value("ESTAT.IS[11] with timer stopped", data[11], 0);
    endtask

    task automatic interrupt_gating();
        csr_pkg::csr_data_t data;
        logic               expected;
        write_csr(`CSR_ECFG, 32'hffff_ffff, 32'hffff_ffff, 1'b1);
        read_csr(`CSR_ECFG, data);
        check_value("ECFG after all ones", data, {19'b0, `ECFG_LIE_MASK});
        for (int is = 0; is < 4; is++) begin
            for (int lie = 0; lie < 4; lie++) begin
                write_csr(`CSR_ESTAT, 32'(is), 32'h0000_0003, 1'b1);
                write_csr(`CSR_ECFG, 32'(lie), 32'hffff_ffff, 1'b1);
                for (int ie = 0; ie < 2; ie++) begin
                    write_csr(`CSR_CRMD, 32'(ie << 2), 32'h0000_0004, 1'b1);
                    @(negedge clk);
                    drive_idle();
                    #1;
                    expected = ((is & lie) != 0) && (ie != 0);
                    check_value($sformatf("has_int is=%0d lie=%0d ie=%0d", is, lie, ie),
                                has_int, expected);
                end
            end
        end
    endtask

    initial begin
        seed_discard = $urandom(32'h0d7e_9eb1);
        reset       = 1'b1;
        valid       = 1'b0;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wvalue  = '0;
        csr_wmask   = '0;
        wb_ex       = 1'b0;
        ertn_flush  = 1'b0;
        wb_ecode    = exc_pkg::ECODE_INT;
        wb_esubcode = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        masked_write_readback();
        exception_entry(exc_pkg::ECODE_ALE, 9'h000, 1'b0);
        exception_entry(exc_pkg::ECODE_ADE, exc_pkg::ESUBCODE_ADEF, 1'b1);
        exception_return();
        oneshot_timer();
        periodic_timer();
        interrupt_gating();

        @(negedge clk);
        drive_idle();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- csr_file.f
+incdir+hw
hw/csr_pkg.sv
hw/exc_pkg.sv
hw/csr_exc_regs.sv
hw/csr_timer.sv
hw/csr_save_regs.sv
hw/csr_file.sv
verification/csr_file_tb.sv

//--- Bender.yml
package:
  name: csr_file

sources:
  - include_dirs:
      - hw
    files:
      - hw/csr_pkg.sv
      - hw/exc_pkg.sv
      - hw/csr_exc_regs.sv
      - hw/csr_timer.sv
      - hw/csr_save_regs.sv
      - hw/csr_file.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verification/csr_file_tb.sv
